// File: src/rob_pkg.sv
package rob_pkg;

  // ------------------------------------------------------------------------
  // buffer geometry
  // ------------------------------------------------------------------------
  localparam int DISP_SIZE      = 4;   // slots per dispatch group
  localparam int CMT_ENTRY_SIZE = 8;
  localparam int CMT_ENTRY_W    = 3;
  localparam int CMT_ID_W       = 4;   // entry index plus wrap bit

  localparam int VADDR_W = 32;
  localparam int XLEN_W  = 32;

  // per-slot mask within a dispatch group
  typedef logic [DISP_SIZE-1:0]   grp_id_t;
  typedef logic [CMT_ID_W-1:0]    cmt_id_t;
  typedef logic [CMT_ENTRY_W-1:0] entry_idx_t;
  typedef logic [VADDR_W-1:0]     vaddr_t;
  typedef logic [XLEN_W-1:0]      xlen_t;

  // ------------------------------------------------------------------------
  // exception causes in mcause encoding
  // ------------------------------------------------------------------------
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN = 4'd0,
    INST_ACC_FAULT     = 4'd1,
    ILLEGAL_INST       = 4'd2,
    BREAKPOINT         = 4'd3,
    LOAD_ACC_FAULT     = 4'd5,
    STORE_ACC_FAULT    = 4'd7,
    ECALL_M            = 4'd11
  } except_t;

endpackage

// File: src/rob_ifs.sv
`timescale 1ns/1ps

// dispatch group load from the allocator into one entry
interface rob_disp_if;
  logic                 load_valid;
  rob_pkg::entry_idx_t  load_idx;   // target entry
  rob_pkg::vaddr_t      pc;
  rob_pkg::grp_id_t     grp_id;

  modport alloc (output load_valid, load_idx, pc, grp_id);
  modport entry (input  load_valid, load_idx, pc, grp_id);
endinterface

// single completion report port
interface rob_done_if;
  logic                 valid;
  rob_pkg::cmt_id_t     cmt_id;
  rob_pkg::grp_id_t     slot;       // one-hot
  logic                 except_valid;
  rob_pkg::except_t     except_type;
  rob_pkg::xlen_t       tval;
  logic                 br_mispred;

  modport src   (output valid, cmt_id, slot, except_valid, except_type, tval, br_mispred);
  modport entry (input  valid, cmt_id, slot, except_valid, except_type, tval, br_mispred);
endinterface

// status of one entry toward the committer
interface rob_entry_if;
  logic                 valid;
  logic                 all_done;
  rob_pkg::grp_id_t     grp_id;
  rob_pkg::vaddr_t      pc;
  rob_pkg::grp_id_t     except_valid;
  rob_pkg::grp_id_t     br_mispred;
  rob_pkg::except_t     except_type [rob_pkg::DISP_SIZE];
  rob_pkg::xlen_t       tval        [rob_pkg::DISP_SIZE];
  logic                 commit_finish;   // frees the entry at commit

  modport entry (
    output valid, all_done, grp_id, pc, except_valid, br_mispred, except_type, tval,
    input  commit_finish
  );
  modport cmt (
    input  valid, all_done, grp_id, pc, except_valid, br_mispred, except_type, tval,
    output commit_finish
  );
endinterface

// File: src/rob_alloc.sv
`timescale 1ns/1ps

module rob_alloc (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_disp_valid,
  input  rob_pkg::vaddr_t   i_disp_pc,
  input  rob_pkg::grp_id_t  i_disp_grp_id,
  input  logic              i_commit,
  output logic              o_disp_ready,
  output rob_pkg::cmt_id_t  o_disp_cmt_id,
  rob_disp_if.alloc         disp
);

  localparam int CNT_W = rob_pkg::CMT_ENTRY_W + 1;

  rob_pkg::cmt_id_t   r_in_cmt_id;
  logic [CNT_W-1:0]   r_count;   // occupied entries from 0 to 8
  logic               w_xfer;

  assign o_disp_ready  = r_count != CNT_W'(rob_pkg::CMT_ENTRY_SIZE);
  assign o_disp_cmt_id = r_in_cmt_id;
  assign w_xfer        = i_disp_valid & o_disp_ready;

  // load goes to the entry under the pointer
  assign disp.load_valid = w_xfer;
  assign disp.load_idx   = r_in_cmt_id[rob_pkg::CMT_ENTRY_W-1:0];
  assign disp.pc         = i_disp_pc;
  assign disp.grp_id     = i_disp_grp_id;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_in_cmt_id <= '0;
      r_count     <= '0;
    end else begin
      if (w_xfer) begin
        r_in_cmt_id <= r_in_cmt_id + rob_pkg::cmt_id_t'(1);   // wraps through bit 3
      end
      case ({w_xfer, i_commit})
        2'b10:   r_count <= r_count + CNT_W'(1);
        2'b01:   r_count <= r_count - CNT_W'(1);
        default: r_count <= r_count;   // none or both in one cycle
      endcase
    end
  end

endmodule

// File: src/rob_entry.sv
`timescale 1ns/1ps

module rob_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic        i_clk,
  input  logic        i_reset_n,
  rob_disp_if.entry   disp,
  rob_done_if.entry   done,
  rob_entry_if.entry  status
);

  logic               r_valid;
  rob_pkg::grp_id_t   r_grp_id;
  rob_pkg::grp_id_t   r_done_grp_id;
  rob_pkg::grp_id_t   r_except_valid;
  rob_pkg::grp_id_t   r_br_mispred;
  rob_pkg::vaddr_t    r_pc;
  rob_pkg::except_t   r_except_type [rob_pkg::DISP_SIZE];
  rob_pkg::xlen_t     r_tval        [rob_pkg::DISP_SIZE];

  logic               w_load;
  logic               w_rpt;

  assign w_load = disp.load_valid &
                  (disp.load_idx == rob_pkg::entry_idx_t'(ENTRY_IDX));
  assign w_rpt  = done.valid & r_valid &
                  (done.cmt_id[rob_pkg::CMT_ENTRY_W-1:0] ==
                   rob_pkg::entry_idx_t'(ENTRY_IDX));

  // ------------------------------------------------------------------------
  // control and mask state
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_grp_id       <= '0;
      r_done_grp_id  <= '0;
      r_except_valid <= '0;
      r_br_mispred   <= '0;
    end else if (status.commit_finish) begin
      r_valid <= 1'b0;
    end else if (w_load) begin
      r_valid        <= 1'b1;
      r_grp_id       <= disp.grp_id;
      r_done_grp_id  <= '0;
      r_except_valid <= '0;
      r_br_mispred   <= '0;
    end else if (w_rpt) begin
      r_done_grp_id <= r_done_grp_id | done.slot;
      for (int d = 0; d < rob_pkg::DISP_SIZE; d++) begin
        if (done.slot[d]) begin
          r_except_valid[d] <= done.except_valid;
          r_br_mispred[d]   <= done.br_mispred;
        end
      end
    end
  end

  // payload qualified by the masks above
  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_pc <= disp.pc;
    end
    if (w_rpt) begin
      for (int d = 0; d < rob_pkg::DISP_SIZE; d++) begin
        if (done.slot[d]) begin
          r_except_type[d] <= done.except_type;
          r_tval[d]        <= done.tval;
        end
      end
    end
  end

  assign status.valid        = r_valid;
  assign status.all_done     = r_valid & (r_done_grp_id == r_grp_id);
  assign status.grp_id       = r_grp_id;
  assign status.pc           = r_pc;
  assign status.except_valid = r_except_valid;
  assign status.br_mispred   = r_br_mispred;
  assign status.except_type  = r_except_type;
  assign status.tval         = r_tval;

endmodule

// File: src/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
  input  logic              i_clk,
  input  logic              i_reset_n,
  rob_entry_if.cmt          ent [rob_pkg::CMT_ENTRY_SIZE],
  output logic              o_commit_valid,
  output rob_pkg::cmt_id_t  o_commit_cmt_id,
  output rob_pkg::grp_id_t  o_commit_grp_id,
  output rob_pkg::grp_id_t  o_commit_except_valid,
  output rob_pkg::except_t  o_commit_except_type,
  output rob_pkg::vaddr_t   o_commit_epc,
  output rob_pkg::xlen_t    o_commit_tval,
  output rob_pkg::grp_id_t  o_commit_dead_id
);

  rob_pkg::cmt_id_t     r_out_cmt_id;
  rob_pkg::entry_idx_t  w_out_idx;

  // entry status flattened for selection by the retire pointer
  logic [rob_pkg::CMT_ENTRY_SIZE-1:0] w_valid;
  logic [rob_pkg::CMT_ENTRY_SIZE-1:0] w_all_done;
  rob_pkg::grp_id_t   w_grp_id       [rob_pkg::CMT_ENTRY_SIZE];
  rob_pkg::vaddr_t    w_pc           [rob_pkg::CMT_ENTRY_SIZE];
  rob_pkg::grp_id_t   w_except_valid [rob_pkg::CMT_ENTRY_SIZE];
  rob_pkg::grp_id_t   w_br_mispred   [rob_pkg::CMT_ENTRY_SIZE];
  rob_pkg::except_t   w_except_type  [rob_pkg::CMT_ENTRY_SIZE][rob_pkg::DISP_SIZE];
  rob_pkg::xlen_t     w_tval         [rob_pkg::CMT_ENTRY_SIZE][rob_pkg::DISP_SIZE];

  rob_pkg::grp_id_t   w_redirect;
  rob_pkg::grp_id_t   w_redirect_oh;
  rob_pkg::grp_id_t   w_alive;
  logic [3:0]         w_type_sel;
  rob_pkg::xlen_t     w_tval_sel;
  rob_pkg::vaddr_t    w_epc_ofs;

  assign w_out_idx = r_out_cmt_id[rob_pkg::CMT_ENTRY_W-1:0];

  for (genvar c = 0; c < rob_pkg::CMT_ENTRY_SIZE; c++) begin : g_ent
    assign w_valid[c]        = ent[c].valid;
    assign w_all_done[c]     = ent[c].all_done;
    assign w_grp_id[c]       = ent[c].grp_id;
    assign w_pc[c]           = ent[c].pc;
    assign w_except_valid[c] = ent[c].except_valid;
    assign w_br_mispred[c]   = ent[c].br_mispred;
    assign w_except_type[c]  = ent[c].except_type;
    assign w_tval[c]         = ent[c].tval;
    assign ent[c].commit_finish = o_commit_valid &
                                  (w_out_idx == rob_pkg::entry_idx_t'(c));
  end

  // ------------------------------------------------------------------------
  // retire pointer at the oldest entry
  // ------------------------------------------------------------------------
  assign o_commit_valid  = w_valid[w_out_idx] & w_all_done[w_out_idx];
  assign o_commit_cmt_id = r_out_cmt_id;
  assign o_commit_grp_id = w_grp_id[w_out_idx];

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_out_cmt_id <= '0;
    end else if (o_commit_valid) begin
      r_out_cmt_id <= r_out_cmt_id + rob_pkg::cmt_id_t'(1);
    end
  end

  // lowest slot that redirects the pc
  assign w_redirect    = w_except_valid[w_out_idx] | w_br_mispred[w_out_idx];
  assign w_redirect_oh = w_redirect & (~w_redirect + rob_pkg::grp_id_t'(1));

  assign o_commit_except_valid = w_except_valid[w_out_idx] & w_redirect_oh;

  always_comb begin
    w_type_sel = '0;
    w_tval_sel = '0;
    w_epc_ofs  = '0;
    for (int d = 0; d < rob_pkg::DISP_SIZE; d++) begin
      if (o_commit_except_valid[d]) begin
        w_type_sel = w_type_sel | w_except_type[w_out_idx][d];
        w_tval_sel = w_tval_sel | w_tval[w_out_idx][d];
      end
      if (w_redirect_oh[d]) begin
        w_epc_ofs = w_epc_ofs | (rob_pkg::vaddr_t'(d) << 2);   // 4 bytes per slot
      end
    end
  end

  assign o_commit_except_type = rob_pkg::except_t'(w_type_sel);
  assign o_commit_epc         = w_pc[w_out_idx] + w_epc_ofs;

  // fetch side faults report the faulting pc itself
  assign o_commit_tval = (o_commit_except_type == rob_pkg::INST_ADDR_MISALIGN ||
                          o_commit_except_type == rob_pkg::INST_ACC_FAULT) ?
                         rob_pkg::xlen_t'(o_commit_epc) : w_tval_sel;

  // slots at and below the redirect stay alive
  // and all of them when nothing redirects
  assign w_alive          = (w_redirect_oh - rob_pkg::grp_id_t'(1)) | w_redirect_oh;
  assign o_commit_dead_id = ~w_alive & o_commit_grp_id;

endmodule

// File: src/rob_top.sv
`timescale 1ns/1ps

module rob_top (
  input  logic              i_clk,
  input  logic              i_reset_n,

  // dispatch
  input  logic              i_disp_valid,
  input  rob_pkg::vaddr_t   i_disp_pc,
  input  rob_pkg::grp_id_t  i_disp_grp_id,
  output logic              o_disp_ready,
  output rob_pkg::cmt_id_t  o_disp_cmt_id,

  // one completion report per cycle
  input  logic              i_done_valid,
  input  rob_pkg::cmt_id_t  i_done_cmt_id,
  input  rob_pkg::grp_id_t  i_done_slot,
  input  logic              i_done_except_valid,
  input  rob_pkg::except_t  i_done_except_type,
  input  rob_pkg::xlen_t    i_done_tval,
  input  logic              i_done_br_mispred,

  // commit
  output logic              o_commit_valid,
  output rob_pkg::cmt_id_t  o_commit_cmt_id,
  output rob_pkg::grp_id_t  o_commit_grp_id,
  output rob_pkg::grp_id_t  o_commit_except_valid,
  output rob_pkg::except_t  o_commit_except_type,
  output rob_pkg::vaddr_t   o_commit_epc,
  output rob_pkg::xlen_t    o_commit_tval,
  output rob_pkg::grp_id_t  o_commit_dead_id
);

  rob_disp_if   u_disp_if ();
  rob_done_if   u_done_if ();
  rob_entry_if  u_ent_if [rob_pkg::CMT_ENTRY_SIZE] ();

  // report port onto the shared bus
  assign u_done_if.valid        = i_done_valid;
  assign u_done_if.cmt_id       = i_done_cmt_id;
  assign u_done_if.slot         = i_done_slot;
  assign u_done_if.except_valid = i_done_except_valid;
  assign u_done_if.except_type  = i_done_except_type;
  assign u_done_if.tval         = i_done_tval;
  assign u_done_if.br_mispred   = i_done_br_mispred;

  rob_alloc u_alloc (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_disp_pc     (i_disp_pc),
    .i_disp_grp_id (i_disp_grp_id),
    .i_commit      (o_commit_valid),   // frees one entry
    .o_disp_ready  (o_disp_ready),
    .o_disp_cmt_id (o_disp_cmt_id),
    .disp          (u_disp_if)
  );

  for (genvar c = 0; c < rob_pkg::CMT_ENTRY_SIZE; c++) begin : g_entry
    rob_entry #(.ENTRY_IDX(c)) u_entry (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .disp      (u_disp_if),
      .done      (u_done_if),
      .status    (u_ent_if[c])
    );
  end

  rob_commit u_commit (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .ent                   (u_ent_if),
    .o_commit_valid        (o_commit_valid),
    .o_commit_cmt_id       (o_commit_cmt_id),
    .o_commit_grp_id       (o_commit_grp_id),
    .o_commit_except_valid (o_commit_except_valid),
    .o_commit_except_type  (o_commit_except_type),
    .o_commit_epc          (o_commit_epc),
    .o_commit_tval         (o_commit_tval),
    .o_commit_dead_id      (o_commit_dead_id)
  );

endmodule

// File: test/rob_assert.sv
`timescale 1ns/1ps

module rob_assert (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_commit_valid,
  input  rob_pkg::grp_id_t  i_commit_grp_id,
  input  rob_pkg::grp_id_t  i_commit_except_valid,
  input  rob_pkg::grp_id_t  i_commit_dead_id
);

  // at most one reported exception per group
  a_except_onehot: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) $onehot0(i_commit_except_valid)
  ) else $error("commit exception mask has more than one bit set");

  // dead slots only among the group's own slots
  a_dead_subset: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      (i_commit_dead_id & ~i_commit_grp_id) == '0
  ) else $error("commit dead mask outside of the group mask");

  a_idle_after_reset: assert property (
    @(posedge i_clk) !i_reset_n |=> !i_commit_valid
  ) else $error("commit valid high right after reset");

endmodule

bind rob_top rob_assert i_rob_assert (
  .i_clk                 (i_clk),
  .i_reset_n             (i_reset_n),
  .i_commit_valid        (o_commit_valid),
  .i_commit_grp_id       (o_commit_grp_id),
  .i_commit_except_valid (o_commit_except_valid),
  .i_commit_dead_id      (o_commit_dead_id)
);

// File: test/tb_rob.sv
`timescale 1ns/1ps

module tb_rob;

  localparam int RUN_CYCLES = 2000;
  localparam int WAIT_LIMIT = 400;
  localparam int NENT       = rob_pkg::CMT_ENTRY_SIZE;
  localparam int NSLOT      = rob_pkg::DISP_SIZE;

  logic                clk;
  logic                reset_n;
  logic                disp_valid;
  rob_pkg::vaddr_t     disp_pc;
  rob_pkg::grp_id_t    disp_grp_id;
  logic                disp_ready;
  rob_pkg::cmt_id_t    disp_cmt_id;
  logic                done_valid;
  rob_pkg::cmt_id_t    done_cmt_id;
  rob_pkg::grp_id_t    done_slot;
  logic                done_except_valid;
  rob_pkg::except_t    done_except_type;
  rob_pkg::xlen_t      done_tval;
  logic                done_br_mispred;
  logic                commit_valid;
  rob_pkg::cmt_id_t    commit_cmt_id;
  rob_pkg::grp_id_t    commit_grp_id;
  rob_pkg::grp_id_t    commit_except_valid;
  rob_pkg::except_t    commit_except_type;
  rob_pkg::vaddr_t     commit_epc;
  rob_pkg::xlen_t      commit_tval;
  rob_pkg::grp_id_t    commit_dead_id;

  // ------------------------------------------------------------------------
  // reference model indexed by entry
  // ------------------------------------------------------------------------
  rob_pkg::vaddr_t     m_pc    [NENT];
  rob_pkg::grp_id_t    m_grp   [NENT];
  rob_pkg::grp_id_t    m_done  [NENT];   // reports captured by the DUT
  rob_pkg::grp_id_t    m_exc   [NENT];
  rob_pkg::grp_id_t    m_mis   [NENT];
  rob_pkg::except_t    m_cause [NENT][NSLOT];
  rob_pkg::xlen_t      m_tval  [NENT][NSLOT];
  rob_pkg::cmt_id_t    m_order [$];      // live groups from the oldest
  rob_pkg::cmt_id_t    next_id;

  int   commit_cnt;
  int   disp_pct;
  int   done_pct;
  logic en_disp;
  logic en_done;
  logic xfer_seen;    // transfer at the coming edge
  logic ready_seen;

  rob_top i_rob_top (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_disp_valid (disp_valid), .i_disp_pc (disp_pc), .i_disp_grp_id (disp_grp_id),
    .o_disp_ready (disp_ready), .o_disp_cmt_id (disp_cmt_id),
    .i_done_valid (done_valid), .i_done_cmt_id (done_cmt_id), .i_done_slot (done_slot),
    .i_done_except_valid (done_except_valid), .i_done_except_type (done_except_type),
    .i_done_tval (done_tval), .i_done_br_mispred (done_br_mispred),
    .o_commit_valid (commit_valid), .o_commit_cmt_id (commit_cmt_id),
    .o_commit_grp_id (commit_grp_id), .o_commit_except_valid (commit_except_valid),
    .o_commit_except_type (commit_except_type), .o_commit_epc (commit_epc),
    .o_commit_tval (commit_tval), .o_commit_dead_id (commit_dead_id)
  );

  always #20 clk = ~clk;

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "stopped at %0t", $time);
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_cmt_id(string name, rob_pkg::cmt_id_t exp, rob_pkg::cmt_id_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_mask(string name, rob_pkg::grp_id_t exp, rob_pkg::grp_id_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_except(string name, rob_pkg::except_t exp, rob_pkg::except_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_vaddr(string name, rob_pkg::vaddr_t exp, rob_pkg::vaddr_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_xlen(string name, rob_pkg::xlen_t exp, rob_pkg::xlen_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  function automatic rob_pkg::entry_idx_t ent_of(rob_pkg::cmt_id_t id);
    return id[rob_pkg::CMT_ENTRY_W-1:0];
  endfunction

  function automatic rob_pkg::except_t pick_cause();
    case ($urandom % 7)
      0:       return rob_pkg::INST_ADDR_MISALIGN;
      1:       return rob_pkg::INST_ACC_FAULT;
      2:       return rob_pkg::ILLEGAL_INST;
      3:       return rob_pkg::BREAKPOINT;
      4:       return rob_pkg::LOAD_ACC_FAULT;
      5:       return rob_pkg::STORE_ACC_FAULT;
      default: return rob_pkg::ECALL_M;
    endcase
  endfunction

  // expected commit of the oldest group
  task automatic check_commit();
    rob_pkg::entry_idx_t ei;
    int                  sel;
    rob_pkg::grp_id_t    exp_exc;
    rob_pkg::grp_id_t    exp_dead;
    rob_pkg::vaddr_t     exp_epc;
    rob_pkg::xlen_t      exp_tval;
    ei       = ent_of(m_order[0]);
    sel      = -1;
    exp_exc  = '0;
    exp_dead = '0;
    for (int d = 0; d < NSLOT; d++) begin
      if (sel < 0 && (m_exc[ei][d] || m_mis[ei][d])) sel = d;
      else if (sel >= 0) exp_dead[d] = m_grp[ei][d];   // younger than the redirect
    end
    check_cmt_id("commit_cmt_id", m_order[0], commit_cmt_id);
    check_mask("commit_grp_id", m_grp[ei], commit_grp_id);
    if (sel >= 0 && m_exc[ei][sel]) exp_exc[sel] = 1'b1;
    check_mask("commit_except_valid", exp_exc, commit_except_valid);
    check_mask("commit_dead_id", exp_dead, commit_dead_id);
    if (sel >= 0) begin
      exp_epc = m_pc[ei] + rob_pkg::vaddr_t'(4 * sel);
      check_vaddr("commit_epc", exp_epc, commit_epc);
    end
    if (exp_exc != '0) begin
      check_except("commit_except_type", m_cause[ei][sel], commit_except_type);
      if (m_cause[ei][sel] == rob_pkg::INST_ADDR_MISALIGN ||
          m_cause[ei][sel] == rob_pkg::INST_ACC_FAULT) exp_tval = exp_epc;
      else exp_tval = m_tval[ei][sel];
      check_xlen("commit_tval", exp_tval, commit_tval);
    end
  endtask

  // ------------------------------------------------------------------------
  // sample on the falling edge and drive on the rising edge
  // ------------------------------------------------------------------------
  task automatic sample_outputs();
    rob_pkg::entry_idx_t ei;
    logic                exp_cv;
    exp_cv = 1'b0;
    if (m_order.size() > 0) exp_cv = m_done[ent_of(m_order[0])] == m_grp[ent_of(m_order[0])];
    check_flag("disp_ready", m_order.size() != NENT, disp_ready);
    check_flag("commit_valid", exp_cv, commit_valid);
    if (commit_valid) begin
      check_commit();
      void'(m_order.pop_front());
      commit_cnt++;
    end
    xfer_seen  = disp_valid && disp_ready;
    ready_seen = disp_ready;
    if (xfer_seen) begin
      check_cmt_id("disp_cmt_id", next_id, disp_cmt_id);
      ei         = ent_of(next_id);
      m_pc[ei]   = disp_pc;
      m_grp[ei]  = disp_grp_id;
      m_done[ei] = '0;
      m_exc[ei]  = '0;
      m_mis[ei]  = '0;
      m_order.push_back(next_id);
      next_id++;
    end
    if (done_valid) begin
      ei = ent_of(done_cmt_id);
      for (int d = 0; d < NSLOT; d++) begin
        if (done_slot[d]) begin
          m_done[ei][d]  = 1'b1;
          m_exc[ei][d]   = done_except_valid;
          m_mis[ei][d]   = done_br_mispred;
          m_cause[ei][d] = done_except_type;
          m_tval[ei][d]  = done_tval;
        end
      end
    end
  endtask

  task automatic drive_inputs();
    int                  cand [$];
    int                  pick;
    rob_pkg::entry_idx_t ei;
    if (!(disp_valid && !xfer_seen)) begin   // held while not ready
      if (en_disp && ($urandom % 100) < disp_pct) begin
        disp_valid  <= 1'b1;
        disp_pc     <= $urandom & 32'hffff_fffc;
        disp_grp_id <= rob_pkg::grp_id_t'($urandom_range(15, 1));
      end else begin
        disp_valid <= 1'b0;
      end
    end
    done_valid <= 1'b0;
    if (en_done && ($urandom % 100) < done_pct) begin
      foreach (m_order[i]) begin
        ei = ent_of(m_order[i]);
        for (int d = 0; d < NSLOT; d++)
          if (m_grp[ei][d] && !m_done[ei][d]) cand.push_back(i * NSLOT + d);
      end
      if (cand.size() > 0) begin
        pick = cand[$urandom % cand.size()];
        done_valid        <= 1'b1;
        done_cmt_id       <= m_order[pick / NSLOT];
        done_slot         <= rob_pkg::grp_id_t'(1) << (pick % NSLOT);
        done_except_valid <= ($urandom % 4) == 0;
        done_except_type  <= pick_cause();
        done_tval         <= $urandom;
        done_br_mispred   <= ($urandom % 4) == 0;
      end
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    sample_outputs();
    @(posedge clk);
    drive_inputs();
  endtask

  initial begin
    int t;
    void'($urandom(32'h71e2));
    clk               = 1'b0;
    reset_n           = 1'b0;
    disp_valid        = 1'b0;
    disp_pc           = '0;
    disp_grp_id       = '0;
    done_valid        = 1'b0;
    done_cmt_id       = '0;
    done_slot         = '0;
    done_except_valid = 1'b0;
    done_except_type  = rob_pkg::INST_ADDR_MISALIGN;
    done_tval         = '0;
    done_br_mispred   = 1'b0;
    commit_cnt        = 0;
    next_id           = '0;
    en_disp           = 1'b1;
    en_done           = 1'b0;
    disp_pct          = 100;
    done_pct          = 100;
    xfer_seen         = 1'b0;
    ready_seen        = 1'b1;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;

    // fill the buffer with no completions
    for (t = 0; t < WAIT_LIMIT && ready_seen; t++) run_cycle();
    if (ready_seen) begin
      $display("dispatch ready never dropped with eight groups in flight");
      stop_run();
    end
    en_done = 1'b1;
    for (t = 0; t < WAIT_LIMIT && !ready_seen; t++) run_cycle();
    if (!ready_seen) begin
      $display("dispatch ready stayed low after completions resumed");
      stop_run();
    end

    // mixed random traffic
    disp_pct = 60;
    done_pct = 70;
    repeat (RUN_CYCLES) run_cycle();

    // drain
    en_disp = 1'b0;
    for (t = 0; t < WAIT_LIMIT && (m_order.size() > 0 || disp_valid); t++) run_cycle();
    if (m_order.size() > 0 || disp_valid) begin
      $display("buffer did not drain, %0d groups left", m_order.size());
      stop_run();
    end
    repeat (4) run_cycle();

    if (commit_cnt > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("no group committed during the run");
      stop_run();
    end
  end

endmodule

// File: flist.f
src/rob_pkg.sv
src/rob_ifs.sv
src/rob_alloc.sv
src/rob_entry.sv
src/rob_commit.sv
src/rob_top.sv
test/rob_assert.sv
test/tb_rob.sv

// File: Bender.yml
package:
  name: rob

sources:
  - files:
      - src/rob_pkg.sv
      - src/rob_ifs.sv
      - src/rob_alloc.sv
      - src/rob_entry.sv
      - src/rob_commit.sv
      - src/rob_top.sv
  - target: test
    files:
      - test/rob_assert.sv
      - test/tb_rob.sv
